/* rf_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Register file package
// Widths, word types and constants shared by the register file,
// its lockstep checker and the alert logic
//////////////////////////////////////////////////////////////////////

package rf_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 5;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned IntgWidth = DataWidth / ByteWidth;
  localparam int unsigned WordWidth = DataWidth + IntgWidth;

  localparam int unsigned NumRegs = 2 ** AddrWidth;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0] reg_addr_t;
  typedef logic [DataWidth-1:0] reg_data_t;

  // One inverted parity bit per data byte, so each byte has odd parity
  typedef logic [IntgWidth-1:0] reg_intg_t;

  // Integrity bits sit above the data
  typedef logic [WordWidth-1:0] reg_word_t;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  // Zero data with valid integrity, i.e. all integrity bits set
  localparam reg_word_t WordZeroVal = {{IntgWidth{1'b1}}, {DataWidth{1'b0}}};

  // Cycles the shadow copy trails the primary copy
  localparam int unsigned LockstepOffset = 2;

endpackage

/* rf_intg_regfile.sv */
//////////////////////////////////////////////////////////////////////
// Integrity register file
// Flip-flop register file of data words with their integrity bits,
// two combinational read ports and one write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_intg_regfile (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              we_i,
  input  rf_pkg::reg_addr_t waddr_i,
  input  rf_pkg::reg_word_t wword_i,

  input  rf_pkg::reg_addr_t raddr_a_i,
  input  rf_pkg::reg_addr_t raddr_b_i,
  output rf_pkg::reg_word_t rword_a_o,
  output rf_pkg::reg_word_t rword_b_o
);

  // Register zero has no storage
  rf_pkg::reg_word_t          rf_q [1:rf_pkg::NumRegs-1];
  logic [rf_pkg::NumRegs-1:1] we_dec;

  // Write address decode
  always_comb begin
    for (int i = 1; i < rf_pkg::NumRegs; i++) begin
      we_dec[i] = we_i && (waddr_i == rf_pkg::reg_addr_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < rf_pkg::NumRegs; i++) begin
        rf_q[i] <= rf_pkg::WordZeroVal;
      end
    end else begin
      for (int i = 1; i < rf_pkg::NumRegs; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= wword_i;
        end
      end
    end
  end

  // Read muxes, default covers register zero
  always_comb begin
    rword_a_o = rf_pkg::WordZeroVal;
    rword_b_o = rf_pkg::WordZeroVal;
    for (int i = 1; i < rf_pkg::NumRegs; i++) begin
      if (raddr_a_i == rf_pkg::reg_addr_t'(i)) begin
        rword_a_o = rf_q[i];
      end
      if (raddr_b_i == rf_pkg::reg_addr_t'(i)) begin
        rword_b_o = rf_q[i];
      end
    end
  end

endmodule

/* rf_lockstep.sv */
//////////////////////////////////////////////////////////////////////
// Register file lockstep checker
// Runs a shadow register file a fixed number of cycles behind the
// primary one and compares the read words of both copies
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_lockstep (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              we_i,
  input  rf_pkg::reg_addr_t waddr_i,
  input  rf_pkg::reg_word_t wword_i,
  input  rf_pkg::reg_addr_t raddr_a_i,
  input  rf_pkg::reg_addr_t raddr_b_i,

  input  rf_pkg::reg_word_t main_rword_a_i,
  input  rf_pkg::reg_word_t main_rword_b_i,

  output logic              mismatch_o
);

  // Delay line stages, last index feeds the shadow copy
  logic              we_q          [rf_pkg::LockstepOffset];
  rf_pkg::reg_addr_t waddr_q       [rf_pkg::LockstepOffset];
  rf_pkg::reg_word_t wword_q       [rf_pkg::LockstepOffset];
  rf_pkg::reg_addr_t raddr_a_q     [rf_pkg::LockstepOffset];
  rf_pkg::reg_addr_t raddr_b_q     [rf_pkg::LockstepOffset];
  rf_pkg::reg_word_t main_rword_a_q[rf_pkg::LockstepOffset];
  rf_pkg::reg_word_t main_rword_b_q[rf_pkg::LockstepOffset];

  rf_pkg::reg_word_t shadow_rword_a;
  rf_pkg::reg_word_t shadow_rword_b;
  logic              mismatch_q;

  //////////////////////////////////////////////////////////////////////
  // Input delay
  //////////////////////////////////////////////////////////////////////

  // Reset values match a freshly reset register file, so no false compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < rf_pkg::LockstepOffset; i++) begin
        we_q[i]           <= 1'b0;
        waddr_q[i]        <= '0;
        wword_q[i]        <= rf_pkg::WordZeroVal;
        raddr_a_q[i]      <= '0;
        raddr_b_q[i]      <= '0;
        main_rword_a_q[i] <= rf_pkg::WordZeroVal;
        main_rword_b_q[i] <= rf_pkg::WordZeroVal;
      end
    end else begin
      we_q[0]           <= we_i;
      waddr_q[0]        <= waddr_i;
      wword_q[0]        <= wword_i;
      raddr_a_q[0]      <= raddr_a_i;
      raddr_b_q[0]      <= raddr_b_i;
      main_rword_a_q[0] <= main_rword_a_i;
      main_rword_b_q[0] <= main_rword_b_i;
      for (int i = 1; i < rf_pkg::LockstepOffset; i++) begin
        we_q[i]           <= we_q[i-1];
        waddr_q[i]        <= waddr_q[i-1];
        wword_q[i]        <= wword_q[i-1];
        raddr_a_q[i]      <= raddr_a_q[i-1];
        raddr_b_q[i]      <= raddr_b_q[i-1];
        main_rword_a_q[i] <= main_rword_a_q[i-1];
        main_rword_b_q[i] <= main_rword_b_q[i-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shadow copy and compare
  //////////////////////////////////////////////////////////////////////

  rf_intg_regfile u_shadow_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we_i     (we_q[rf_pkg::LockstepOffset-1]),
    .waddr_i  (waddr_q[rf_pkg::LockstepOffset-1]),
    .wword_i  (wword_q[rf_pkg::LockstepOffset-1]),
    .raddr_a_i(raddr_a_q[rf_pkg::LockstepOffset-1]),
    .raddr_b_i(raddr_b_q[rf_pkg::LockstepOffset-1]),
    .rword_a_o(shadow_rword_a),
    .rword_b_o(shadow_rword_b)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q <= 1'b0;
    end else begin
      mismatch_q <= (shadow_rword_a != main_rword_a_q[rf_pkg::LockstepOffset-1]) ||
                    (shadow_rword_b != main_rword_b_q[rf_pkg::LockstepOffset-1]);
    end
  end

  assign mismatch_o = mismatch_q;

endmodule

/* rf_alert.sv */
//////////////////////////////////////////////////////////////////////
// Register file alert
// Checks the integrity bits of both read words and folds integrity
// errors and lockstep mismatch into a sticky major alert
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_alert (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  rf_pkg::reg_word_t rword_a_i,
  input  rf_pkg::reg_word_t rword_b_i,
  input  logic              mismatch_i,

  output logic              alert_major_o
);

  rf_pkg::reg_intg_t intg_a_exp;
  rf_pkg::reg_intg_t intg_b_exp;
  logic              intg_err_a;
  logic              intg_err_b;
  logic              alert_q;

  // Inverted XOR per byte
  function automatic rf_pkg::reg_intg_t calc_intg(rf_pkg::reg_data_t data);
    rf_pkg::reg_intg_t intg;
    for (int n = 0; n < rf_pkg::IntgWidth; n++) begin
      intg[n] = ~^data[n*rf_pkg::ByteWidth +: rf_pkg::ByteWidth];
    end
    return intg;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Integrity check
  //////////////////////////////////////////////////////////////////////

  assign intg_a_exp = calc_intg(rword_a_i[rf_pkg::DataWidth-1:0]);
  assign intg_b_exp = calc_intg(rword_b_i[rf_pkg::DataWidth-1:0]);

  assign intg_err_a = intg_a_exp != rword_a_i[rf_pkg::WordWidth-1:rf_pkg::DataWidth];
  assign intg_err_b = intg_b_exp != rword_b_i[rf_pkg::WordWidth-1:rf_pkg::DataWidth];

  //////////////////////////////////////////////////////////////////////
  // Sticky alert
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | intg_err_a | intg_err_b | mismatch_i;
    end
  end

  // Mismatch is already a flop output, pass it on without another stage
  assign alert_major_o = alert_q | mismatch_i;

endmodule

/* rf_top.sv */
//////////////////////////////////////////////////////////////////////
// Protected register file top
// Primary register file with integrity bits, lockstep shadow checker
// and sticky major alert
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Write port
  input  logic              we_i,
  input  rf_pkg::reg_addr_t waddr_i,
  input  rf_pkg::reg_data_t wdata_i,
  input  rf_pkg::reg_intg_t wintg_i,

  // Read ports
  input  rf_pkg::reg_addr_t raddr_a_i,
  input  rf_pkg::reg_addr_t raddr_b_i,
  output rf_pkg::reg_data_t rdata_a_o,
  output rf_pkg::reg_data_t rdata_b_o,

  output logic              alert_major_o
);

  rf_pkg::reg_word_t wword;
  rf_pkg::reg_word_t rword_a;
  rf_pkg::reg_word_t rword_b;
  logic              mismatch;

  // Integrity bits go above the data
  assign wword = {wintg_i, wdata_i};

  //////////////////////////////////////////////////////////////////////
  // Primary copy and lockstep checker
  //////////////////////////////////////////////////////////////////////

  rf_intg_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we_i     (we_i),
    .waddr_i  (waddr_i),
    .wword_i  (wword),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .rword_a_o(rword_a),
    .rword_b_o(rword_b)
  );

  rf_lockstep u_lockstep (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .we_i          (we_i),
    .waddr_i       (waddr_i),
    .wword_i       (wword),
    .raddr_a_i     (raddr_a_i),
    .raddr_b_i     (raddr_b_i),
    .main_rword_a_i(rword_a),
    .main_rword_b_i(rword_b),
    .mismatch_o    (mismatch)
  );

  rf_alert u_alert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rword_a_i    (rword_a),
    .rword_b_i    (rword_b),
    .mismatch_i   (mismatch),
    .alert_major_o(alert_major_o)
  );

  assign rdata_a_o = rword_a[rf_pkg::DataWidth-1:0];
  assign rdata_b_o = rword_b[rf_pkg::DataWidth-1:0];

endmodule

/* rf_top_sva.sv */
//////////////////////////////////////////////////////////////////////
// Register file top assertions
// Alert and register-zero properties on the top-level ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_top_sva (
  input logic              clk_i,
  input logic              rst_ni,
  input rf_pkg::reg_addr_t raddr_a_i,
  input rf_pkg::reg_addr_t raddr_b_i,
  input rf_pkg::reg_data_t rdata_a_o,
  input rf_pkg::reg_data_t rdata_b_o,
  input logic              alert_major_o
);

  alert_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o))
    else $error("alert_major_o is unknown");

  // Sticky until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major_o |=> alert_major_o)
    else $error("alert_major_o dropped without reset");

  zero_read_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_a_i == '0) |-> (rdata_a_o == '0))
    else $error("register zero read nonzero on port A");

  zero_read_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_b_i == '0) |-> (rdata_b_o == '0))
    else $error("register zero read nonzero on port B");

endmodule

bind rf_top rf_top_sva i_rf_top_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .raddr_a_i    (raddr_a_i),
  .raddr_b_i    (raddr_b_i),
  .rdata_a_o    (rdata_a_o),
  .rdata_b_o    (rdata_b_o),
  .alert_major_o(alert_major_o)
);

/* tb_rf_top.sv */
//////////////////////////////////////////////////////////////////////
// Register file testbench
// Table-driven stimulus against a reference model of data,
// integrity state and sticky alert
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rf_top;

  localparam int unsigned ResetCycles = 5;
  localparam int unsigned RandRows    = 40;

  typedef struct packed {
    logic              we;
    rf_pkg::reg_addr_t waddr;
    rf_pkg::reg_data_t wdata;
    logic              rnd;
    logic              flip;
    rf_pkg::reg_addr_t raddr_a;
    rf_pkg::reg_addr_t raddr_b;
  } row_t;

  logic              clk_i;
  logic              rst_ni;
  logic              we_i;
  rf_pkg::reg_addr_t waddr_i;
  rf_pkg::reg_data_t wdata_i;
  rf_pkg::reg_intg_t wintg_i;
  rf_pkg::reg_addr_t raddr_a_i;
  rf_pkg::reg_addr_t raddr_b_i;
  rf_pkg::reg_data_t rdata_a_o;
  rf_pkg::reg_data_t rdata_b_o;
  logic              alert_major_o;

  row_t              rows[$];
  rf_pkg::reg_data_t model_data[rf_pkg::NumRegs];
  logic              model_good[rf_pkg::NumRegs];
  logic              model_alert;
  logic [31:0]       rand_state;
  int unsigned       err_cnt;
  int unsigned       check_cnt;
  int unsigned       cycle_cnt;
  int unsigned       cycle_limit;

  rf_top i_rf_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .we_i         (we_i),
    .waddr_i      (waddr_i),
    .wdata_i      (wdata_i),
    .wintg_i      (wintg_i),
    .raddr_a_i    (raddr_a_i),
    .raddr_b_i    (raddr_b_i),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o),
    .alert_major_o(alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Each byte plus its bit has odd parity
  function automatic rf_pkg::reg_intg_t odd_parity_bits(rf_pkg::reg_data_t data);
    rf_pkg::reg_intg_t bits;
    for (int n = 0; n < 4; n++) begin
      bits[n] = ~(^data[8*n +: 8]);
    end
    return bits;
  endfunction

  task automatic add_row(input logic we, input int waddr, input logic [31:0] wdata,
                         input logic rnd, input logic flip, input int ra, input int rb);
    row_t r;
    r.we      = we;
    r.waddr   = rf_pkg::reg_addr_t'(waddr);
    r.wdata   = wdata;
    r.rnd     = rnd;
    r.flip    = flip;
    r.raddr_a = rf_pkg::reg_addr_t'(ra);
    r.raddr_b = rf_pkg::reg_addr_t'(rb);
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] pick;
    // Reset contents of every register on both ports
    for (int i = 0; i < 16; i++) begin
      add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, i, i + 16);
    end
    for (int i = 0; i < 16; i++) begin
      add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, i + 16, i);
    end
    add_row(1'b1, 1, 32'h1234_5678, 1'b0, 1'b0, 1, 1);
    add_row(1'b1, 2, 32'hcafe_f00d, 1'b0, 1'b0, 1, 1);
    add_row(1'b1, 31, 32'h8000_0001, 1'b0, 1'b0, 1, 2);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 2, 31);
    // Register zero ignores writes
    add_row(1'b1, 0, 32'hdead_beef, 1'b0, 1'b0, 0, 0);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 0, 1);
    // Random correct traffic with data filled in when applied
    for (int i = 0; i < RandRows; i++) begin
      rand_state = xorshift32(rand_state);
      pick = rand_state;
      add_row(pick[0], int'(pick[12:8]), 32'h0, 1'b1, 1'b0,
              int'(pick[20:16]), int'(pick[28:24]));
    end
    // Bad word on r7 overwritten before it is read
    add_row(1'b1, 7, 32'h0f0f_1111, 1'b0, 1'b1, 3, 4);
    add_row(1'b1, 7, 32'h0f0f_1111, 1'b0, 1'b0, 3, 4);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 7, 7);
    // Bad word on r5 read later
    add_row(1'b1, 5, 32'h5555_aaaa, 1'b0, 1'b1, 6, 8);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 1, 2);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 31, 0);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 0, 5);
    add_row(1'b1, 9, 32'h0000_0099, 1'b0, 1'b0, 9, 1);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 9, 2);
    add_row(1'b0, 0, 32'h0, 1'b0, 1'b0, 0, 0);
  endtask

  task automatic check_outputs(input rf_pkg::reg_addr_t ra, input rf_pkg::reg_addr_t rb);
    rf_pkg::reg_data_t exp_a;
    rf_pkg::reg_data_t exp_b;
    exp_a = model_data[ra];
    exp_b = model_data[rb];
    check_cnt = check_cnt + 3;
    if (rdata_a_o !== exp_a) begin
      err_cnt++;
      $display("FAILED rdata_a_o (raddr %h): expected %h, got %h", ra, exp_a, rdata_a_o);
    end
    if (rdata_b_o !== exp_b) begin
      err_cnt++;
      $display("FAILED rdata_b_o (raddr %h): expected %h, got %h", rb, exp_b, rdata_b_o);
    end
    if (alert_major_o !== model_alert) begin
      err_cnt++;
      $display("FAILED alert_major_o: expected %h, got %h", model_alert, alert_major_o);
    end
  endtask

  task automatic update_model(input logic we, input rf_pkg::reg_addr_t wa,
                              input rf_pkg::reg_data_t data, input logic flip,
                              input rf_pkg::reg_addr_t ra, input rf_pkg::reg_addr_t rb);
    // Bad word on a read port raises the alert at the next edge
    if (!model_good[ra] || !model_good[rb]) begin
      model_alert = 1'b1;
    end
    if (we && wa != '0) begin
      model_data[wa] = data;
      model_good[wa] = !flip;
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Run timed out after %0d cycles before the table was done", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    row_t              row;
    rf_pkg::reg_data_t data;
    rst_ni    <= 1'b0;
    we_i      <= 1'b0;
    waddr_i   <= '0;
    wdata_i   <= '0;
    wintg_i   <= '0;
    raddr_a_i <= '0;
    raddr_b_i <= '0;
    err_cnt     = 0;
    check_cnt   = 0;
    cycle_cnt   = 0;
    rand_state  = 32'h7134;
    model_alert = 1'b0;
    for (int i = 0; i < rf_pkg::NumRegs; i++) begin
      model_data[i] = '0;
      model_good[i] = 1'b1;
    end
    build_table();
    cycle_limit = 2 * rows.size() + ResetCycles + 20;

    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (rows[k]) begin
      row  = rows[k];
      data = row.wdata;
      if (row.rnd) begin
        rand_state = xorshift32(rand_state);
        data = rand_state;
      end
      @(posedge clk_i);
      we_i      <= row.we;
      waddr_i   <= row.waddr;
      wdata_i   <= data;
      wintg_i   <= odd_parity_bits(data) ^ (row.flip ? 4'b0100 : 4'b0000);
      raddr_a_i <= row.raddr_a;
      raddr_b_i <= row.raddr_b;
      // Outputs settled by mid-cycle
      @(negedge clk_i);
      check_outputs(row.raddr_a, row.raddr_b);
      update_model(row.we, row.waddr, data, row.flip, row.raddr_a, row.raddr_b);
    end

    $display("Summary: %0d errors in %0d checks", err_cnt, check_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* rf_top.f */
rf_pkg.sv
rf_intg_regfile.sv
rf_lockstep.sv
rf_alert.sv
rf_top.sv
rf_top_sva.sv
tb_rf_top.sv

/* Makefile */
# Verilator build and regression run for the protected register file

TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rf_top
FILELIST  ?= rf_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "test: FAIL, run incomplete"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
